// ==== Makefile ====
SIM       = verilator
VFLAGS    = --binary --timing
TOP       = msp_trace_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search the log for the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/msp_inst_classify.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msp_trace_defines.svh"

module msp_inst_classify (
  input  wire                            mclk,
  input  wire                            puc_rst,
  input  wire                            s1_valid,
  input  wire msp_trace_pkg::opcode_t    s1_opcode,
  input  wire                            s1_irq,
  input  wire msp_trace_pkg::irq_num_t   s1_irq_num,
  input  wire msp_trace_pkg::pc_t        s1_pc,
  input  wire msp_trace_pkg::count_t     s1_number,
  output logic                           s2_valid,
  output msp_trace_pkg::inst_class_e     s2_class,
  output msp_trace_pkg::opcode_t         s2_opcode,
  output msp_trace_pkg::text_t           s2_name,    // Mnemonic only
  output logic                           s2_bw,      // Byte op
  output msp_trace_pkg::reg_idx_t        s2_src,
  output msp_trace_pkg::reg_idx_t        s2_dst,
  output msp_trace_pkg::amode_t          s2_as,
  output logic                           s2_ad,
  output msp_trace_pkg::pc_t             s2_pc,
  output msp_trace_pkg::count_t          s2_number
);

  msp_trace_pkg::inst_class_e cls;
  msp_trace_pkg::text_t       name;
  logic [7:0]                 irq_digit;  // Last ASCII digit of "IRQ n"

  // ============================================================
  // Class and mnemonic
  // ============================================================

  always_comb begin
    if (s1_irq) begin
      cls = msp_trace_pkg::CLS_IRQ;  // Interrupt wins over opcode
    end else begin
      case (s1_opcode[15:13])
        3'b000:  cls = msp_trace_pkg::CLS_SIG_OP;
        3'b001:  cls = msp_trace_pkg::CLS_JUMP;
        default: cls = msp_trace_pkg::CLS_TWO_OP;
      endcase
    end
  end

  // Tens digit handled by the prefix below
  always_comb begin
    if (s1_irq_num > 4'd9) begin
      irq_digit = 8'h30 + {4'h0, s1_irq_num - 4'd10};
    end else begin
      irq_digit = 8'h30 + {4'h0, s1_irq_num};
    end
  end

  always_comb begin
    name = "xxxx";  // Unknown single-operand codes
    case (cls)
      msp_trace_pkg::CLS_IRQ: begin
        if (s1_irq_num == 4'd15) begin
          name = "RESET";
        end else if (s1_irq_num == 4'd14) begin
          name = "NMI";
        end else if (s1_irq_num > 4'd9) begin
          name = msp_trace_pkg::text_t'({"IRQ 1", irq_digit});
        end else begin
          name = msp_trace_pkg::text_t'({"IRQ ", irq_digit});
        end
      end
      msp_trace_pkg::CLS_SIG_OP: begin
        case (s1_opcode[15:7])
          9'b000100_000: name = "RRC";
          9'b000100_001: name = "SWPB";
          9'b000100_010: name = "RRA";
          9'b000100_011: name = "SXT";
          9'b000100_100: name = "PUSH";
          9'b000100_101: name = "CALL";
          9'b000100_110: name = "RETI";
          default:       name = "xxxx";
        endcase
      end
      msp_trace_pkg::CLS_JUMP: begin
        case (s1_opcode[12:10])  // Condition field
          3'd0:    name = "JNE";
          3'd1:    name = "JEQ";
          3'd2:    name = "JNC";
          3'd3:    name = "JC";
          3'd4:    name = "JN";
          3'd5:    name = "JGE";
          3'd6:    name = "JL";
          default: name = "JMP";
        endcase
      end
      default: begin
        case (s1_opcode[15:12])
          4'h4:    name = "MOV";
          4'h5:    name = "ADD";
          4'h6:    name = "ADDC";
          4'h7:    name = "SUBC";
          4'h8:    name = "SUB";
          4'h9:    name = "CMP";
          4'hA:    name = "DADD";
          4'hB:    name = "BIT";
          4'hC:    name = "BIC";
          4'hD:    name = "BIS";
          4'hE:    name = "XOR";
          4'hF:    name = "AND";
          default: name = "xxxx";  // Not reachable for this class
        endcase
      end
    endcase
  end

  // ============================================================
  // Stage 2 registers
  // ============================================================

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge mclk) begin
    if (s1_valid) begin
      s2_class  <= cls;
      s2_opcode <= s1_opcode;
      s2_name   <= name;
      s2_bw     <= s1_opcode[6];
      // Format II keeps its only register in the low nibble
      s2_src    <= (cls == msp_trace_pkg::CLS_SIG_OP) ? s1_opcode[3:0] : s1_opcode[11:8];
      s2_dst    <= s1_opcode[3:0];
      s2_as     <= s1_opcode[5:4];
      s2_ad     <= s1_opcode[7];
      s2_pc     <= s1_pc;
      s2_number <= s1_number;
    end
  end

endmodule

`default_nettype wire

// ==== design/msp_inst_format.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msp_trace_defines.svh"

module msp_inst_format (
  input  wire                              mclk,
  input  wire                              puc_rst,
  input  wire                              s2_valid,
  input  wire msp_trace_pkg::inst_class_e  s2_class,
  input  wire msp_trace_pkg::opcode_t      s2_opcode,
  input  wire msp_trace_pkg::text_t        s2_name,
  input  wire                              s2_bw,
  input  wire msp_trace_pkg::reg_idx_t     s2_src,
  input  wire msp_trace_pkg::reg_idx_t     s2_dst,
  input  wire msp_trace_pkg::amode_t       s2_as,
  input  wire                              s2_ad,
  input  wire msp_trace_pkg::pc_t          s2_pc,
  input  wire msp_trace_pkg::count_t       s2_number,
  output logic                             o_trace_valid,  // One pulse per record
  output msp_trace_pkg::pc_t               o_inst_pc,
  output msp_trace_pkg::count_t            o_inst_number,
  output msp_trace_pkg::text_t             o_inst_short,   // Mnemonic
  output msp_trace_pkg::text_t             o_inst_full     // Disassembly
);

  // ============================================================
  // Text helpers
  // ============================================================

  // Characters in use, text is zero above its first char
  function automatic int str_len(input msp_trace_pkg::text_t s);
    int len;
    len = 0;
    for (int i = 0; i < `TRC_TEXT_CHARS; i++) begin
      if (s[8*i +: 8] != 8'h00) begin
        len = i + 1;
      end
    end
    return len;
  endfunction

  // Append tail after head, shifting head up by the tail length
  function automatic msp_trace_pkg::text_t str_cat(input msp_trace_pkg::text_t head,
                                                   input msp_trace_pkg::text_t tail);
    return (head << (8 * str_len(tail))) | tail;
  endfunction

  // "r0" .. "r15"
  function automatic msp_trace_pkg::text_t reg_text(input msp_trace_pkg::reg_idx_t r);
    logic [7:0] digit;
    if (r > 4'd9) begin
      digit = 8'h30 + {4'h0, r - 4'd10};
      return msp_trace_pkg::text_t'({"r1", digit});
    end
    digit = 8'h30 + {4'h0, r};
    return msp_trace_pkg::text_t'({"r", digit});
  endfunction

  msp_trace_pkg::text_t src_reg_txt;
  msp_trace_pkg::text_t dst_reg_txt;
  msp_trace_pkg::text_t src_txt;
  msp_trace_pkg::text_t dst_txt;
  msp_trace_pkg::text_t full_txt;
  logic                 sig_has_op;  // Format II with a printed operand

  // ============================================================
  // Operands
  // ============================================================

  always_comb begin
    src_reg_txt = reg_text(s2_src);
    if (s2_src == 4'd3) begin  // CG2 constants
      case (s2_as)
        2'b00:   src_txt = "#0";
        2'b01:   src_txt = "#1";
        2'b10:   src_txt = "#2";
        default: src_txt = "#-1";
      endcase
    end else if (s2_src == 4'd2) begin  // SR, absolute or CG1
      case (s2_as)
        2'b00:   src_txt = src_reg_txt;
        2'b01:   src_txt = "&EDE";
        2'b10:   src_txt = "#4";
        default: src_txt = "#8";
      endcase
    end else if (s2_src == 4'd0) begin  // PC, symbolic or immediate
      case (s2_as)
        2'b00:   src_txt = src_reg_txt;
        2'b01:   src_txt = "EDE";
        2'b10:   src_txt = str_cat("@", src_reg_txt);
        default: src_txt = "#N";
      endcase
    end else begin
      case (s2_as)
        2'b00:   src_txt = src_reg_txt;
        2'b01:   src_txt = str_cat(str_cat("x(", src_reg_txt), ")");
        2'b10:   src_txt = str_cat("@", src_reg_txt);
        default: src_txt = str_cat(str_cat("@", src_reg_txt), "+");
      endcase
    end
  end

  always_comb begin
    dst_reg_txt = reg_text(s2_dst);
    if (!s2_ad) begin
      dst_txt = dst_reg_txt;  // Register direct
    end else if (s2_dst == 4'd2) begin
      dst_txt = "&EDE";
    end else if (s2_dst == 4'd0) begin
      dst_txt = "EDE";
    end else begin
      dst_txt = str_cat(str_cat("x(", dst_reg_txt), ")");
    end
  end

  // ============================================================
  // Full line
  // ============================================================

  // RETI and unknown codes print no operand
  assign sig_has_op = (s2_opcode[15:10] == 6'b000100) && (s2_opcode[9:7] < 3'b110);

  always_comb begin
    full_txt = s2_name;  // Jumps, IRQs, RETI, xxxx
    if ((s2_class == msp_trace_pkg::CLS_TWO_OP) ||
        ((s2_class == msp_trace_pkg::CLS_SIG_OP) && sig_has_op)) begin
      full_txt = str_cat(s2_name, s2_bw ? msp_trace_pkg::text_t'(".B") : '0);
      full_txt = str_cat(str_cat(full_txt, " "), src_txt);
    end
    if (s2_class == msp_trace_pkg::CLS_TWO_OP) begin
      full_txt = str_cat(str_cat(full_txt, ", "), dst_txt);
    end
    // Emulated forms override the generic line
    if (s2_class != msp_trace_pkg::CLS_IRQ) begin
      if (s2_opcode == `NOP_OP) begin
        full_txt = "NOP";
      end else if (s2_opcode == `DBG_SWBRK_OP) begin
        full_txt = "SBREAK";
      end
    end
  end

  // ============================================================
  // Record registers
  // ============================================================

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      o_trace_valid <= 1'b0;
      o_inst_number <= '0;
      o_inst_pc     <= '0;
    end else begin
      o_trace_valid <= s2_valid;
      if (s2_valid) begin
        o_inst_number <= s2_number;
        o_inst_pc     <= s2_pc;
      end
    end
  end

  always_ff @(posedge mclk) begin
    if (s2_valid) begin
      o_inst_short <= s2_name;
      o_inst_full  <= full_txt;
    end
  end

endmodule

`default_nettype wire

// ==== design/msp_state_namer.sv ====
`timescale 1ns/1ps
`default_nettype none

module msp_state_namer (
  input  wire msp_trace_pkg::istate_t  i_i_state_bin,  // Fetch FSM code
  input  wire msp_trace_pkg::estate_t  i_e_state_bin,  // Execution FSM code
  output msp_trace_pkg::text_t         o_i_state,
  output msp_trace_pkg::text_t         o_e_state
);

  // ============================================================
  // Fetch FSM names
  // ============================================================

  always_comb begin
    case (i_i_state_bin)
      3'd0:    o_i_state = "IRQ_FETCH";
      3'd1:    o_i_state = "IRQ_DONE";
      3'd2:    o_i_state = "DEC";
      3'd3:    o_i_state = "EXT1";
      3'd4:    o_i_state = "EXT2";
      3'd5:    o_i_state = "IDLE";
      default: o_i_state = "XXXXX";  // Unused codes 6, 7
    endcase
  end

  // ============================================================
  // Execution FSM names
  // ============================================================

  // IRQ_0..IRQ_2 are numbered backwards in the core encoding
  always_comb begin
    case (i_e_state_bin)
      4'h2:    o_e_state = "IRQ_0";
      4'h1:    o_e_state = "IRQ_1";
      4'h0:    o_e_state = "IRQ_2";
      4'h3:    o_e_state = "IRQ_3";
      4'h4:    o_e_state = "IRQ_4";
      4'h5:    o_e_state = "SRC_AD";
      4'h6:    o_e_state = "SRC_RD";
      4'h7:    o_e_state = "SRC_WR";
      4'h8:    o_e_state = "DST_AD";
      4'h9:    o_e_state = "DST_RD";
      4'hA:    o_e_state = "DST_WR";
      4'hB:    o_e_state = "EXEC";
      4'hC:    o_e_state = "JUMP";
      4'hD:    o_e_state = "IDLE";
      default: o_e_state = "xxxx";
    endcase
  end

endmodule

`default_nettype wire

// ==== design/msp_trace_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module msp_trace_capture (
  input  wire                            mclk,          // Main clock
  input  wire                            puc_rst,       // Async reset, high
  input  wire                            i_decode,      // One strobe per instruction
  input  wire msp_trace_pkg::opcode_t    i_ir,          // Instruction register
  input  wire msp_trace_pkg::pc_t        i_pc,          // Program counter
  input  wire                            i_irq_detect,  // Item is an IRQ entry
  input  wire msp_trace_pkg::irq_num_t   i_irq_num,     // Vector number
  output logic                           s1_valid,
  output msp_trace_pkg::opcode_t         s1_opcode,
  output logic                           s1_irq,
  output msp_trace_pkg::irq_num_t        s1_irq_num,
  output msp_trace_pkg::pc_t             s1_pc,
  output msp_trace_pkg::count_t          s1_number,     // Running instruction ordinal
  output msp_trace_pkg::count_t          o_inst_cycle   // Cycles in current instruction
);

  // ============================================================
  // Stage 1 strobe
  // ============================================================

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= i_decode;  // Exactly one cycle per decode
    end
  end

  // Payload, only moves on decode
  always_ff @(posedge mclk) begin
    if (i_decode) begin
      s1_opcode  <= i_ir;
      s1_irq     <= i_irq_detect;
      s1_irq_num <= i_irq_num;
      s1_pc      <= i_pc;
    end
  end

  // ============================================================
  // Counters
  // ============================================================

  // Ordinal bumps with the opcode, so the first record is 1
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      s1_number <= '0;
    end else if (i_decode) begin
      s1_number <= s1_number + 32'd1;
    end
  end

  // Free running, restarts at every decode
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      o_inst_cycle <= '0;
    end else if (i_decode) begin
      o_inst_cycle <= '0;
    end else begin
      o_inst_cycle <= o_inst_cycle + 32'd1;
    end
  end

endmodule

`default_nettype wire

// ==== design/msp_trace_defines.svh ====
`ifndef MSP_TRACE_DEFINES_SVH
`define MSP_TRACE_DEFINES_SVH

// ============================================================
// Trace text geometry
// ============================================================

// Characters per text field, last char in the lowest byte
`define TRC_TEXT_CHARS 32

// ============================================================
// Opcodes printed with their own names
// ============================================================

`define DBG_SWBRK_OP 16'h4343  // Software breakpoint
`define NOP_OP       16'h4303  // MOV #0, r3

`endif

// ==== design/msp_trace_pkg.sv ====
`default_nettype none

`include "msp_trace_defines.svh"

package msp_trace_pkg;

  // ============================================================
  // Core-side fields
  // ============================================================

  typedef logic [15:0] opcode_t;    // Instruction word
  typedef logic [15:0] pc_t;        // Byte address
  typedef logic [31:0] count_t;     // Ordinals and cycle counts

  typedef logic [3:0]  reg_idx_t;   // r0..r15
  typedef logic [3:0]  irq_num_t;   // 14 is NMI, 15 is reset vector
  typedef logic [1:0]  amode_t;     // As field

  // Fetch and execution FSM codes, as the core encodes them
  typedef logic [2:0]  istate_t;
  typedef logic [3:0]  estate_t;

  // ============================================================
  // Trace side
  // ============================================================

  // ASCII text, right aligned, zero filled above
  typedef logic [8*`TRC_TEXT_CHARS-1:0] text_t;

  // Instruction format class
  typedef enum logic [1:0] {
    CLS_IRQ,     // Interrupt entry, no opcode
    CLS_SIG_OP,  // Format II
    CLS_JUMP,    // Format III
    CLS_TWO_OP   // Format I
  } inst_class_e;

endpackage

`default_nettype wire

// ==== design/msp_trace_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module msp_trace_top (
  input  wire                            mclk,
  input  wire                            puc_rst,
  input  wire                            i_decode,
  input  wire msp_trace_pkg::opcode_t    i_ir,
  input  wire msp_trace_pkg::pc_t        i_pc,
  input  wire                            i_irq_detect,
  input  wire msp_trace_pkg::irq_num_t   i_irq_num,
  input  wire msp_trace_pkg::istate_t    i_i_state_bin,
  input  wire msp_trace_pkg::estate_t    i_e_state_bin,
  output logic                           o_trace_valid,
  output msp_trace_pkg::pc_t             o_inst_pc,
  output msp_trace_pkg::count_t          o_inst_number,
  output msp_trace_pkg::text_t           o_inst_short,
  output msp_trace_pkg::text_t           o_inst_full,
  output msp_trace_pkg::count_t          o_inst_cycle,
  output msp_trace_pkg::text_t           o_i_state,
  output msp_trace_pkg::text_t           o_e_state
);

  // ============================================================
  // Capture to classify
  // ============================================================
  logic                        s1_valid;
  msp_trace_pkg::opcode_t      s1_opcode;
  logic                        s1_irq;
  msp_trace_pkg::irq_num_t     s1_irq_num;
  msp_trace_pkg::pc_t          s1_pc;
  msp_trace_pkg::count_t       s1_number;

  // ============================================================
  // Classify to format
  // ============================================================
  logic                        s2_valid;
  msp_trace_pkg::inst_class_e  s2_class;
  msp_trace_pkg::opcode_t      s2_opcode;
  msp_trace_pkg::text_t        s2_name;
  logic                        s2_bw;
  msp_trace_pkg::reg_idx_t     s2_src;
  msp_trace_pkg::reg_idx_t     s2_dst;
  msp_trace_pkg::amode_t       s2_as;
  logic                        s2_ad;
  msp_trace_pkg::pc_t          s2_pc;
  msp_trace_pkg::count_t       s2_number;

  // Port names line up stage to stage
  msp_trace_capture u_capture   (.*);
  msp_inst_classify u_classify  (.*);
  msp_inst_format   u_format    (.*);

  // Live FSM names, no pipeline delay
  msp_state_namer   u_state_namer (.*);

endmodule

`default_nettype wire

// ==== dv/msp_trace_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msp_trace_defines.svh"

module msp_trace_checker (
  input  wire                           mclk,
  input  wire                           puc_rst,
  input  wire                           i_decode,
  input  wire msp_trace_pkg::opcode_t   i_ir,
  input  wire msp_trace_pkg::pc_t       i_pc,
  input  wire                           i_irq_detect,
  input  wire msp_trace_pkg::irq_num_t  i_irq_num,
  input  wire msp_trace_pkg::istate_t   i_i_state_bin,
  input  wire msp_trace_pkg::estate_t   i_e_state_bin,
  input  wire                           i_trace_valid,   // DUT record strobe
  input  wire msp_trace_pkg::pc_t       i_inst_pc,
  input  wire msp_trace_pkg::count_t    i_inst_number,
  input  wire msp_trace_pkg::text_t     i_inst_short,
  input  wire msp_trace_pkg::text_t     i_inst_full,
  input  wire msp_trace_pkg::count_t    i_inst_cycle,
  input  wire msp_trace_pkg::text_t     i_i_state_txt,   // DUT o_i_state
  input  wire msp_trace_pkg::text_t     i_e_state_txt,   // DUT o_e_state
  output logic [31:0]                   o_error_count,
  output logic [31:0]                   o_record_count
);

  // ============================================================
  // Name tables
  // ============================================================
  string sig_names [8]   = '{"RRC", "SWPB", "RRA", "SXT", "PUSH", "CALL", "RETI", "xxxx"};
  string jmp_names [8]   = '{"JNE", "JEQ", "JNC", "JC", "JN", "JGE", "JL", "JMP"};
  string two_names [16]  = '{"xxxx", "xxxx", "xxxx", "xxxx", "MOV", "ADD", "ADDC", "SUBC",
                             "SUB", "CMP", "DADD", "BIT", "BIC", "BIS", "XOR", "AND"};
  string fetch_names [8] = '{"IRQ_FETCH", "IRQ_DONE", "DEC", "EXT1", "EXT2", "IDLE",
                             "XXXXX", "XXXXX"};
  // IRQ_0..IRQ_2 sit at codes 2, 1, 0
  string exec_names [16] = '{"IRQ_2", "IRQ_1", "IRQ_0", "IRQ_3", "IRQ_4", "SRC_AD", "SRC_RD",
                             "SRC_WR", "DST_AD", "DST_RD", "DST_WR", "EXEC", "JUMP", "IDLE",
                             "xxxx", "xxxx"};

  msp_trace_pkg::pc_t    pc_q [$];      // Expected records, oldest first
  msp_trace_pkg::count_t num_q [$];
  msp_trace_pkg::text_t  short_q [$];
  msp_trace_pkg::text_t  full_q [$];
  logic [2:0]            in_flight = '0;  // Decode seen 1..3 negedges back
  msp_trace_pkg::count_t decode_cnt = '0;
  msp_trace_pkg::count_t exp_cycle = '0;
  msp_trace_pkg::count_t exp_number = '0;  // Last ordinal at the output
  int                    errors = 0;
  int                    records = 0;

  assign o_error_count  = errors;
  assign o_record_count = records;

  // ============================================================
  // Reference model
  // ============================================================

  // Right aligned, last char in byte 0
  function automatic msp_trace_pkg::text_t to_text(input string s);
    msp_trace_pkg::text_t t;
    t = '0;
    for (int i = 0; i < s.len(); i++) begin
      t = {t[8*`TRC_TEXT_CHARS-9:0], s[i]};
    end
    return t;
  endfunction

  function automatic string show(input msp_trace_pkg::text_t t);
    string s;
    s = "";
    for (int i = `TRC_TEXT_CHARS - 1; i >= 0; i--) begin
      if (t[8*i +: 8] != 8'h00) s = $sformatf("%s%c", s, t[8*i +: 8]);
    end
    return s;
  endfunction

  function automatic string src_operand(input logic [3:0] r, input logic [1:0] as);
    string rn;
    rn = $sformatf("r%0d", r);
    if (r == 4'd3) begin  // Constant generator 2
      case (as)
        2'd0:    return "#0";
        2'd1:    return "#1";
        2'd2:    return "#2";
        default: return "#-1";
      endcase
    end
    if (as == 2'd0) return rn;
    if (r == 4'd2) begin
      case (as)
        2'd1:    return "&EDE";
        2'd2:    return "#4";
        default: return "#8";
      endcase
    end
    if (as == 2'd2) return {"@", rn};
    if (as == 2'd1) begin
      if (r == 4'd0) return "EDE";
      return {"x(", rn, ")"};
    end
    if (r == 4'd0) return "#N";  // Immediate
    return {"@", rn, "+"};
  endfunction

  function automatic string dst_operand(input logic [3:0] r, input logic ad);
    string rn;
    rn = $sformatf("r%0d", r);
    if (!ad) return rn;
    if (r == 4'd2) return "&EDE";
    if (r == 4'd0) return "EDE";
    return {"x(", rn, ")"};
  endfunction

  function automatic string mnemonic(input logic [15:0] ir, input logic irq,
                                     input logic [3:0] num);
    if (irq) begin
      if (num == 4'd15) return "RESET";
      if (num == 4'd14) return "NMI";
      return $sformatf("IRQ %0d", num);
    end
    if (ir[15:13] == 3'b001) return jmp_names[ir[12:10]];
    if (ir[15:13] != 3'b000) return two_names[ir[15:12]];
    if (ir[15:10] == 6'b000100) return sig_names[ir[9:7]];
    return "xxxx";
  endfunction

  function automatic string disasm(input logic [15:0] ir, input logic irq,
                                   input logic [3:0] num);
    string name;
    string bsuf;
    name = mnemonic(ir, irq, num);
    bsuf = "";
    if (ir[6]) bsuf = ".B";
    if (irq) return name;
    if (ir == `NOP_OP) return "NOP";
    if (ir == `DBG_SWBRK_OP) return "SBREAK";
    if (ir[15:14] != 2'b00) begin  // Format I
      return {name, bsuf, " ", src_operand(ir[11:8], ir[5:4]), ", ",
              dst_operand(ir[3:0], ir[7])};
    end
    if ((ir[15:13] == 3'b000) && (name != "RETI") && (name != "xxxx")) begin
      return {name, bsuf, " ", src_operand(ir[3:0], ir[5:4])};
    end
    return name;  // Jumps, RETI, unknown
  endfunction

  // ============================================================
  // Compare
  // ============================================================

  task automatic check_num(input string sig, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected 0x%0h got 0x%0h", $time, sig, exp, act);
      errors++;
    end
  endtask

  task automatic check_text(input string sig, input msp_trace_pkg::text_t exp,
                            input msp_trace_pkg::text_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected \"%s\" got \"%s\"", $time, sig, show(exp),
               show(act));
      errors++;
    end
  endtask

  // Sample mid cycle, away from the driving edge
  always @(negedge mclk) begin
    check_num("o_trace_valid", {31'd0, in_flight[2]}, {31'd0, i_trace_valid});
    if (i_trace_valid) begin
      records++;
      if (pc_q.size() == 0) begin
        $display("Error at %0t: trace record with no decode outstanding", $time);
        errors++;
      end else begin
        exp_number = num_q.pop_front();
        check_num("o_inst_pc", {16'h0, pc_q.pop_front()}, {16'h0, i_inst_pc});
        check_text("o_inst_short", short_q.pop_front(), i_inst_short);
        check_text("o_inst_full", full_q.pop_front(), i_inst_full);
      end
    end
    check_num("o_inst_number", exp_number, i_inst_number);
    check_num("o_inst_cycle", exp_cycle, i_inst_cycle);
    check_text("o_i_state", to_text(fetch_names[i_i_state_bin]), i_i_state_txt);
    check_text("o_e_state", to_text(exec_names[i_e_state_bin]), i_e_state_txt);

    // Advance to what the next rising edge produces
    if (puc_rst) begin
      in_flight  = '0;
      decode_cnt = '0;
      exp_cycle  = '0;
      exp_number = '0;
      pc_q.delete();
      num_q.delete();
      short_q.delete();
      full_q.delete();
    end else begin
      exp_cycle = i_decode ? 0 : exp_cycle + 1;
      in_flight = {in_flight[1:0], i_decode};
      if (i_decode) begin
        decode_cnt++;  // First record is 1
        pc_q.push_back(i_pc);
        num_q.push_back(decode_cnt);
        short_q.push_back(to_text(mnemonic(i_ir, i_irq_detect, i_irq_num)));
        full_q.push_back(to_text(disasm(i_ir, i_irq_detect, i_irq_num)));
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/msp_trace_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msp_trace_defines.svh"

module msp_trace_tb;

  localparam int RESET_CYCLES    = 8;
  localparam int TEST_CYCLES     = 6000;
  localparam int PHASE_CYCLES    = 150;  // Decode density changes this often
  localparam int DRAIN_CYCLES    = 6;    // Pipeline is three deep
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + DRAIN_CYCLES + 100;

  logic                    mclk = 1'b0;
  logic                    puc_rst;
  logic                    i_decode;
  msp_trace_pkg::opcode_t  i_ir;
  msp_trace_pkg::pc_t      i_pc;
  logic                    i_irq_detect;
  msp_trace_pkg::irq_num_t i_irq_num;
  msp_trace_pkg::istate_t  i_i_state_bin;
  msp_trace_pkg::estate_t  i_e_state_bin;
  logic                    o_trace_valid;
  msp_trace_pkg::pc_t      o_inst_pc;
  msp_trace_pkg::count_t   o_inst_number;
  msp_trace_pkg::text_t    o_inst_short;
  msp_trace_pkg::text_t    o_inst_full;
  msp_trace_pkg::count_t   o_inst_cycle;
  msp_trace_pkg::text_t    o_i_state;
  msp_trace_pkg::text_t    o_e_state;

  logic [31:0] error_count;
  logic [31:0] record_count;
  integer      seed = 32'h752c6a23;
  logic [31:0] rnd;
  logic [1:0]  density;       // 0 back to back, 1 half, 2 sparse, 3 rare
  logic        want;
  int          decodes_sent;
  int          end_errors;

  always #50 mclk = ~mclk;  // 100 ns period

  msp_trace_top msp_trace_top_inst (.*);

  msp_trace_checker u_checker (
    .mclk           (mclk),
    .puc_rst        (puc_rst),
    .i_decode       (i_decode),
    .i_ir           (i_ir),
    .i_pc           (i_pc),
    .i_irq_detect   (i_irq_detect),
    .i_irq_num      (i_irq_num),
    .i_i_state_bin  (i_i_state_bin),
    .i_e_state_bin  (i_e_state_bin),
    .i_trace_valid  (o_trace_valid),
    .i_inst_pc      (o_inst_pc),
    .i_inst_number  (o_inst_number),
    .i_inst_short   (o_inst_short),
    .i_inst_full    (o_inst_full),
    .i_inst_cycle   (o_inst_cycle),
    .i_i_state_txt  (o_i_state),
    .i_e_state_txt  (o_e_state),
    .o_error_count  (error_count),
    .o_record_count (record_count)
  );

  // ============================================================
  // Stimulus
  // ============================================================

  // One decoded item biased toward every class and the special registers
  task automatic drive_item();
    logic [31:0] r;
    logic [31:0] op;
    logic [3:0]  src;
    logic [3:0]  dst;
    r   = $random(seed);
    op  = $random(seed);
    src = r[12] ? {2'b00, r[14:13]} : op[11:8];  // r0..r3 half the time
    dst = r[15] ? {2'b00, r[17:16]} : op[3:0];
    i_irq_detect <= 1'b0;
    i_irq_num    <= r[23:20];
    i_pc         <= {op[31:17], 1'b0};
    case (r[3:0])
      4'd0: begin
        i_irq_detect <= 1'b1;
        i_ir         <= r[4] ? `NOP_OP : op[15:0];  // NOP must not override IRQ
      end
      4'd1:             i_ir <= `NOP_OP;
      4'd2:             i_ir <= `DBG_SWBRK_OP;
      4'd3, 4'd4, 4'd5: i_ir <= {6'b000100, op[9:4], src};  // Format II, RETI, code 7
      4'd6:             i_ir <= {3'b000, op[12:0]};        // Mostly illegal
      4'd7, 4'd8:       i_ir <= {3'b001, op[12:0]};        // Jumps
      default:          i_ir <= {4'd4 + (r[11:8] % 4'd12), src, op[7:4], dst};
    endcase
  endtask

  initial begin
    puc_rst       = 1'b1;
    i_decode      = 1'b0;
    i_ir          = '0;
    i_pc          = '0;
    i_irq_detect  = 1'b0;
    i_irq_num     = '0;
    i_i_state_bin = '0;
    i_e_state_bin = '0;
    density       = 2'd0;
    decodes_sent  = 0;
    end_errors    = 0;
    repeat (RESET_CYCLES) @(posedge mclk);
    puc_rst <= 1'b0;
    for (int cyc = 0; cyc < TEST_CYCLES; cyc++) begin
      @(posedge mclk);
      rnd = $random(seed);
      if (cyc % PHASE_CYCLES == 0) density = rnd[9:8];
      i_i_state_bin <= rnd[2:0];  // All codes including the unknown ones
      i_e_state_bin <= rnd[6:3];
      case (density)
        2'd0:    want = 1'b1;
        2'd1:    want = rnd[7];
        2'd2:    want = (rnd[12:10] == 3'd0);
        default: want = (rnd[15:11] == 5'd0);
      endcase
      i_decode <= want;
      if (want) begin
        drive_item();
        decodes_sent++;
      end
    end
    @(posedge mclk);
    i_decode <= 1'b0;
    repeat (DRAIN_CYCLES) @(posedge mclk);

    if (record_count != decodes_sent) begin
      $display("Mismatch at %0t: record_count expected %0d got %0d", $time, decodes_sent,
               record_count);
      end_errors++;
    end
    $display("Errors: %0d, records: %0d, decodes: %0d", error_count + end_errors,
             record_count, decodes_sent);
    if ((error_count == 0) && (end_errors == 0)) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // ============================================================
  // Watchdog
  // ============================================================
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge mclk);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/msp_trace_pkg.sv
design/msp_trace_capture.sv
design/msp_inst_classify.sv
design/msp_inst_format.sv
design/msp_state_namer.sv
design/msp_trace_top.sv
dv/msp_trace_checker.sv
dv/msp_trace_tb.sv
